// File: common/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // one instruction or memory data word
    typedef logic [31:0] word_t;

    // byte address as seen by the core
    typedef logic [31:0] addr_t;

    // cache controller states
    // REFILL waits for the burst, RESPOND writes the block and returns the word
    typedef enum logic [1:0] {
        IDLE,
        REFILL,
        RESPOND
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: common/mem_read_if.sv
`timescale 1ns/1ns
`default_nettype none

interface mem_read_if;

    // block-aligned address, held with request
    icache_pkg::addr_t addr;
    // level, high until all beats are counted
    logic              request;
    icache_pkg::word_t data;
    // one strobe per returned word
    logic              data_ready;

    modport cache (
        output addr,
        output request,
        input  data,
        input  data_ready
    );

    modport mem (
        input  addr,
        input  request,
        output data,
        output data_ready
    );

endinterface

`default_nettype wire

// File: icache/icache.sv
`timescale 1ns/1ns
`default_nettype none

module icache #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  wire logic              Clk,
    input  wire logic              rst_n,
    input  wire logic              read_enable,
    input  wire icache_pkg::addr_t read_address,
    output icache_pkg::word_t      instruction,
    output logic                   ready,
    output logic                   busy,
    mem_read_if.cache              mem
);

    localparam int OFF_W = $clog2(BLOCK_WORDS);
    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int WAY_W = $clog2(NUM_WAYS);
    localparam int TAG_W = 32 - IDX_W - OFF_W - 2;

    logic [IDX_W-1:0]    lookup_set;
    logic [TAG_W-1:0]    lookup_tag;
    logic [OFF_W-1:0]    word_sel;
    logic                hit;
    icache_pkg::word_t   hit_word;
    logic [NUM_WAYS-1:0] set_valid;
    logic                fill_en;
    logic [WAY_W-1:0]    fill_way;
    logic [TAG_W-1:0]    fill_tag;
    icache_pkg::word_t   fill_block [BLOCK_WORDS];

    icache_ctrl #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_ctrl (
        .Clk          (Clk),
        .rst_n        (rst_n),
        .read_enable  (read_enable),
        .read_address (read_address),
        .instruction  (instruction),
        .ready        (ready),
        .busy         (busy),
        .mem          (mem),
        .lookup_set   (lookup_set),
        .lookup_tag   (lookup_tag),
        .word_sel     (word_sel),
        .hit          (hit),
        .hit_word     (hit_word),
        .set_valid    (set_valid),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .fill_tag     (fill_tag),
        .fill_block   (fill_block)
    );

    icache_storage #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_storage (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .lookup_set (lookup_set),
        .lookup_tag (lookup_tag),
        .word_sel   (word_sel),
        .hit        (hit),
        .hit_word   (hit_word),
        .set_valid  (set_valid),
        .fill_en    (fill_en),
        .fill_way   (fill_way),
        .fill_tag   (fill_tag),
        .fill_block (fill_block)
    );

endmodule

`default_nettype wire

// File: icache/icache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module icache_ctrl #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4,
    localparam int OFF_W      = $clog2(BLOCK_WORDS),
    localparam int IDX_W      = $clog2(NUM_SETS),
    localparam int WAY_W      = $clog2(NUM_WAYS),
    localparam int TAG_W      = 32 - IDX_W - OFF_W - 2
) (
    input  wire logic              Clk,
    input  wire logic              rst_n,
    input  wire logic              read_enable,
    input  wire icache_pkg::addr_t read_address,
    output icache_pkg::word_t      instruction,
    output logic                   ready,
    output logic                   busy,
    mem_read_if.cache              mem,
    output logic [IDX_W-1:0]       lookup_set,
    output logic [TAG_W-1:0]       lookup_tag,
    output logic [OFF_W-1:0]       word_sel,
    input  wire logic              hit,
    input  wire icache_pkg::word_t hit_word,
    input  wire logic [NUM_WAYS-1:0] set_valid,
    output logic                   fill_en,
    output logic [WAY_W-1:0]       fill_way,
    output logic [TAG_W-1:0]       fill_tag,
    output icache_pkg::word_t      fill_block [BLOCK_WORDS]
);

    localparam int IDX_LO = OFF_W + 2;
    localparam int TAG_LO = IDX_LO + IDX_W;

    icache_pkg::ctrl_state_t state;
    icache_pkg::addr_t       miss_addr;
    icache_pkg::addr_t       cur_addr;
    icache_pkg::word_t       block_buf [BLOCK_WORDS];
    icache_pkg::word_t       target_word;
    logic [WAY_W-1:0]        miss_way;
    logic [WAY_W-1:0]        victim_way;
    logic [OFF_W-1:0]        beat_cnt;
    logic [15:0]             lfsr;
    logic                    in_idle;
    logic                    last_beat;

    assign in_idle  = (state == icache_pkg::IDLE);
    // look up the core address when idle, the miss address otherwise
    assign cur_addr   = in_idle ? read_address : miss_addr;
    assign lookup_set = cur_addr[TAG_LO-1:IDX_LO];
    assign lookup_tag = cur_addr[31:TAG_LO];
    assign word_sel   = cur_addr[IDX_LO-1:2];

    assign busy        = !in_idle;
    assign mem.request = (state == icache_pkg::REFILL);
    assign mem.addr    = {miss_addr[31:IDX_LO], {IDX_LO{1'b0}}};
    assign last_beat   = mem.data_ready && (beat_cnt == OFF_W'(BLOCK_WORDS - 1));

    assign fill_en    = (state == icache_pkg::RESPOND);
    assign fill_way   = miss_way;
    assign fill_tag   = miss_addr[31:TAG_LO];
    assign fill_block = block_buf;

    // lowest invalid way wins, otherwise take the lfsr
    always_comb begin
        victim_way = lfsr[WAY_W-1:0];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                victim_way = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            state    <= icache_pkg::IDLE;
            ready    <= 1'b0;
            beat_cnt <= '0;
            lfsr     <= 16'hACE1;
        end else begin
            ready <= 1'b0;
            // galois step, taps 16,14,13,11
            lfsr  <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
            case (state)
                icache_pkg::IDLE: begin
                    if (read_enable && hit) begin
                        ready <= 1'b1;
                    end else if (read_enable) begin
                        state    <= icache_pkg::REFILL;
                        beat_cnt <= '0;
                    end
                end
                icache_pkg::REFILL: begin
                    if (mem.data_ready) begin
                        beat_cnt <= beat_cnt + OFF_W'(1);
                    end
                    if (last_beat) begin
                        state <= icache_pkg::RESPOND;
                    end
                end
                icache_pkg::RESPOND: begin
                    ready <= 1'b1;
                    state <= icache_pkg::IDLE;
                end
                default: state <= icache_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (in_idle && read_enable) begin
            if (hit) begin
                instruction <= hit_word;
            end else begin
                miss_addr <= read_address;
                miss_way  <= victim_way;
            end
        end
        // keep the requested word as it goes by
        if (state == icache_pkg::REFILL && mem.data_ready) begin
            block_buf[beat_cnt] <= mem.data;
            if (beat_cnt == miss_addr[IDX_LO-1:2]) begin
                target_word <= mem.data;
            end
        end
        if (state == icache_pkg::RESPOND) begin
            instruction <= target_word;
        end
    end

endmodule

`default_nettype wire

// File: icache/icache_storage.sv
`timescale 1ns/1ns
`default_nettype none

module icache_storage #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4,
    localparam int OFF_W      = $clog2(BLOCK_WORDS),
    localparam int IDX_W      = $clog2(NUM_SETS),
    localparam int WAY_W      = $clog2(NUM_WAYS),
    localparam int TAG_W      = 32 - IDX_W - OFF_W - 2
) (
    input  wire logic              Clk,
    input  wire logic              rst_n,
    input  wire logic [IDX_W-1:0]  lookup_set,
    input  wire logic [TAG_W-1:0]  lookup_tag,
    input  wire logic [OFF_W-1:0]  word_sel,
    output logic                   hit,
    output icache_pkg::word_t      hit_word,
    output logic [NUM_WAYS-1:0]    set_valid,
    input  wire logic              fill_en,
    input  wire logic [WAY_W-1:0]  fill_way,
    input  wire logic [TAG_W-1:0]  fill_tag,
    input  wire icache_pkg::word_t fill_block [BLOCK_WORDS]
);

    logic [TAG_W-1:0]    tag_mem  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q  [NUM_SETS];
    icache_pkg::word_t   data_mem [NUM_SETS][NUM_WAYS][BLOCK_WORDS];
    logic [NUM_WAYS-1:0] way_match;

    assign set_valid = valid_q[lookup_set];
    assign hit       = |way_match;

    // compare all ways of the set in parallel
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_match[w] = valid_q[lookup_set][w] && (tag_mem[lookup_set][w] == lookup_tag);
        end
    end

    // at most one way matches, so a plain or-style select is enough
    always_comb begin
        hit_word = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_match[w]) begin
                hit_word = data_mem[lookup_set][w][word_sel];
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (fill_en) begin
            valid_q[lookup_set][fill_way] <= 1'b1;
        end
    end

    // whole block and tag land in one cycle
    always_ff @(posedge Clk) begin
        if (fill_en) begin
            tag_mem[lookup_set][fill_way] <= fill_tag;
            for (int b = 0; b < BLOCK_WORDS; b++) begin
                data_mem[lookup_set][fill_way][b] <= fill_block[b];
            end
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the fetch path testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found"
    exit 1
fi

if ! verilator --binary --timing -f sources.f --top-module tb_fetch -o sim_fetch; then
    echo "build failed"
    exit 1
fi

if ! out=$(./obj_dir/sim_fetch); then
    printf '%s\n' "$out"
    echo "simulation exited with an error"
    exit 1
fi
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

// File: sources.f
common/icache_pkg.sv
common/mem_read_if.sv
icache/icache_storage.sv
icache/icache_ctrl.sv
icache/icache.sv
verilog/burst_mem.sv
verilog/fetch_top.sv
tests/tb_clkgen.sv
tests/tb_fetch.sv

// File: tests/tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic Clk,
    output logic rst_n
);

    initial begin
        Clk = 1'b0;
        forever #HALF_PERIOD Clk = ~Clk;
    end

    // release just after an edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge Clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tests/tb_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fetch;

    localparam int NUM_SETS     = 8;
    localparam int NUM_WAYS     = 4;
    localparam int BLOCK_WORDS  = 4;
    localparam int MEM_LATENCY  = 3;
    localparam int MEM_WORDS    = 1024;
    localparam int AW           = $clog2(MEM_WORDS);
    localparam int RESET_CYCLES = 10;
    localparam int READ_CYCLES  = 40;
    localparam int MISS_WAIT    = 32;
    // cold miss, block readback, set fill, eviction, reset, dropped strobe
    localparam int NUM_READS    = 1 + BLOCK_WORDS + 2 * NUM_WAYS + (NUM_WAYS + 2) + 2 + 1;
    localparam int CYCLE_LIMIT  = READ_CYCLES * NUM_READS + MEM_WORDS + 2 * RESET_CYCLES;

    logic              Clk;
    logic              gen_rst_n;
    logic              soft_rst_n;
    logic              rst_n;
    logic              read_enable;
    icache_pkg::addr_t read_address;
    icache_pkg::word_t instruction;
    logic              ready;
    logic              busy;
    logic              prog_we;
    icache_pkg::addr_t prog_addr;
    icache_pkg::word_t prog_data;

    icache_pkg::word_t mem_copy [MEM_WORDS];
    logic [31:0]       lfsr_state;
    int                word_errors;
    int                flag_errors;
    int                other_errors;
    int                cycle_cnt;

    assign rst_n = gen_rst_n & soft_rst_n;

    tb_clkgen #(
        .HALF_PERIOD  (4),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clkgen (
        .Clk   (Clk),
        .rst_n (gen_rst_n)
    );

    fetch_top #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS),
        .MEM_LATENCY (MEM_LATENCY),
        .MEM_WORDS   (MEM_WORDS)
    ) uut (
        .Clk          (Clk),
        .rst_n        (rst_n),
        .read_enable  (read_enable),
        .read_address (read_address),
        .instruction  (instruction),
        .ready        (ready),
        .busy         (busy),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data)
    );

    // galois form of x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    task automatic random_word(output icache_pkg::word_t w);
        logic out_bit;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
            w          = {w[30:0], out_bit};
        end
    endtask

    // byte address of one word in a block with the given set and tag
    function automatic icache_pkg::addr_t block_addr(input int set_i, input int tag_i,
                                                     input int word_i);
        return icache_pkg::addr_t'(((tag_i * NUM_SETS + set_i) * BLOCK_WORDS + word_i) * 4);
    endfunction

    function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t a);
        return mem_copy[a[AW+1:2]];
    endfunction

    task automatic check_word(input string name, input icache_pkg::word_t actual,
                              input icache_pkg::word_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
            word_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, actual, expected);
            flag_errors++;
        end
    endtask

    task automatic load_memory();
        icache_pkg::word_t w;
        for (int i = 0; i < MEM_WORDS; i++) begin
            random_word(w);
            mem_copy[i] = w;
            prog_we     = 1'b1;
            prog_addr   = icache_pkg::addr_t'(i * 4);
            prog_data   = w;
            @(posedge Clk);
            #1;
        end
        prog_we = 1'b0;
    endtask

    // one read, waits for ready and checks the word; missed tells if busy rose
    task automatic read_word(input icache_pkg::addr_t addr, output logic missed);
        int waited;
        waited       = 0;
        read_enable  = 1'b1;
        read_address = addr;
        @(posedge Clk);
        #1;
        read_enable = 1'b0;
        missed      = busy;
        while (!ready && waited < MISS_WAIT) begin
            @(posedge Clk);
            #1;
            waited++;
        end
        if (ready) begin
            check_flag("busy", busy, 1'b0);
            check_word("instruction", instruction, expected_word(addr));
        end else begin
            $display("read of %h got no ready pulse within %0d cycles", addr, MISS_WAIT);
            other_errors++;
        end
        @(posedge Clk);
        #1;
        check_flag("ready", ready, 1'b0);
    endtask

    task automatic cold_miss_test();
        logic missed;
        read_word(block_addr(0, 0, 1), missed);
        check_flag("busy", missed, 1'b1);
    endtask

    task automatic block_hit_test();
        icache_pkg::addr_t a;
        for (int w = 0; w < BLOCK_WORDS; w++) begin
            a            = block_addr(0, 0, w);
            read_enable  = 1'b1;
            read_address = a;
            @(posedge Clk);
            #1;
            check_flag("busy", busy, 1'b0);
            check_flag("ready", ready, 1'b1);
            check_word("instruction", instruction, expected_word(a));
        end
        read_enable = 1'b0;
        @(posedge Clk);
        #1;
        check_flag("ready", ready, 1'b0);
    endtask

    task automatic set_fill_test();
        logic missed;
        for (int t = 0; t < NUM_WAYS; t++) begin
            read_word(block_addr(2, t, t % BLOCK_WORDS), missed);
            check_flag("busy", missed, 1'b1);
        end
        // invalid ways went first, so nothing was evicted
        for (int t = 0; t < NUM_WAYS; t++) begin
            read_word(block_addr(2, t, (t + 1) % BLOCK_WORDS), missed);
            check_flag("busy", missed, 1'b0);
        end
    endtask

    task automatic eviction_test();
        logic missed;
        int   miss_cnt;
        miss_cnt = 0;
        read_word(block_addr(2, NUM_WAYS, 3), missed);
        check_flag("busy", missed, 1'b1);
        for (int t = 0; t <= NUM_WAYS; t++) begin
            read_word(block_addr(2, t, (t + 2) % BLOCK_WORDS), missed);
            if (missed) begin
                miss_cnt++;
            end
        end
        if (miss_cnt == 0) begin
            $display("no re-read missed after a block was evicted from the full set");
            other_errors++;
        end
    endtask

    task automatic reset_valid_test();
        logic missed;
        read_word(block_addr(0, 0, 2), missed);
        check_flag("busy", missed, 1'b0);
        soft_rst_n = 1'b0;
        repeat (2) @(posedge Clk);
        #1;
        soft_rst_n = 1'b1;
        check_flag("busy", busy, 1'b0);
        check_flag("ready", ready, 1'b0);
        read_word(block_addr(0, 0, 2), missed);
        check_flag("busy", missed, 1'b1);
    endtask

    task automatic dropped_strobe_test();
        icache_pkg::addr_t a;
        int                waited;
        a            = block_addr(5, 1, 2);
        waited       = 0;
        read_enable  = 1'b1;
        read_address = a;
        @(posedge Clk);
        #1;
        read_enable = 1'b0;
        check_flag("busy", busy, 1'b1);
        @(posedge Clk);
        #1;
        // this one would hit if the controller took it
        read_enable  = 1'b1;
        read_address = block_addr(0, 0, 1);
        @(posedge Clk);
        #1;
        read_enable = 1'b0;
        check_flag("ready", ready, 1'b0);
        while (!ready && waited < MISS_WAIT) begin
            @(posedge Clk);
            #1;
            waited++;
        end
        if (ready) begin
            check_flag("busy", busy, 1'b0);
            check_word("instruction", instruction, expected_word(a));
        end else begin
            $display("miss with a dropped strobe got no ready pulse");
            other_errors++;
        end
        repeat (4) begin
            @(posedge Clk);
            #1;
            check_flag("ready", ready, 1'b0);
        end
    endtask

    always @(posedge Clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        cycle_cnt    = 0;
        read_enable  = 1'b0;
        read_address = '0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        soft_rst_n   = 1'b1;
        lfsr_state   = 32'h6707;
        word_errors  = 0;
        flag_errors  = 0;
        other_errors = 0;
        wait (gen_rst_n === 1'b1);
        load_memory();
        cold_miss_test();
        block_hit_test();
        set_fill_test();
        eviction_test();
        reset_valid_test();
        dropped_strobe_test();
        $display("errors: %0d word, %0d flag, %0d other", word_errors, flag_errors,
                 other_errors);
        if (word_errors + flag_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/burst_mem.sv
`timescale 1ns/1ns
`default_nettype none

module burst_mem #(
    parameter int BLOCK_WORDS = 4,
    parameter int MEM_LATENCY = 3,
    parameter int MEM_WORDS   = 1024
) (
    input  wire logic              Clk,
    input  wire logic              rst_n,
    mem_read_if.mem                bus,
    input  wire logic              prog_we,
    input  wire icache_pkg::addr_t prog_addr,
    input  wire icache_pkg::word_t prog_data
);

    localparam int AW    = $clog2(MEM_WORDS);
    localparam int OFF_W = $clog2(BLOCK_WORDS);
    localparam int LAT_W = $clog2(MEM_LATENCY + 1);

    icache_pkg::word_t   mem_array [MEM_WORDS];
    logic                active;
    logic                wait_low;
    logic [LAT_W-1:0]    lat_cnt;
    logic [OFF_W-1:0]    beat_cnt;
    logic [AW-OFF_W-1:0] block_idx;
    logic                start;
    logic                beat_go;

    assign start   = !wait_low && !active && bus.request;
    // first beat once the latency has run out, then one per cycle
    // since lat_cnt holds its end value through the burst
    assign beat_go = active && lat_cnt == LAT_W'(MEM_LATENCY - 1);

    always_ff @(posedge Clk) begin
        if (prog_we) begin
            mem_array[prog_addr[AW+1:2]] <= prog_data;
        end
    end

    always_ff @(posedge Clk) begin
        if (start) begin
            block_idx <= bus.addr[AW+1:OFF_W+2];
        end
        if (beat_go) begin
            bus.data <= mem_array[{block_idx, beat_cnt}];
        end
    end

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            active         <= 1'b0;
            wait_low       <= 1'b0;
            lat_cnt        <= '0;
            beat_cnt       <= '0;
            bus.data_ready <= 1'b0;
        end else begin
            bus.data_ready <= 1'b0;
            if (wait_low) begin
                // burst done, hold off until request drops
                if (!bus.request) begin
                    wait_low <= 1'b0;
                end
            end else if (start) begin
                active   <= 1'b1;
                lat_cnt  <= '0;
                beat_cnt <= '0;
            end else if (beat_go) begin
                bus.data_ready <= 1'b1;
                beat_cnt       <= beat_cnt + OFF_W'(1);
                if (beat_cnt == OFF_W'(BLOCK_WORDS - 1)) begin
                    active   <= 1'b0;
                    wait_low <= 1'b1;
                end
            end else if (active) begin
                lat_cnt <= lat_cnt + LAT_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4,
    parameter int MEM_LATENCY = 3,
    parameter int MEM_WORDS   = 1024
) (
    input  wire logic              Clk,
    input  wire logic              rst_n,
    input  wire logic              read_enable,
    input  wire icache_pkg::addr_t read_address,
    output icache_pkg::word_t      instruction,
    output logic                   ready,
    output logic                   busy,
    input  wire logic              prog_we,
    input  wire icache_pkg::addr_t prog_addr,
    input  wire icache_pkg::word_t prog_data
);

    // block read channel between cache and memory
    mem_read_if mem_bus ();

    icache #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_icache (
        .Clk          (Clk),
        .rst_n        (rst_n),
        .read_enable  (read_enable),
        .read_address (read_address),
        .instruction  (instruction),
        .ready        (ready),
        .busy         (busy),
        .mem          (mem_bus.cache)
    );

    burst_mem #(
        .BLOCK_WORDS (BLOCK_WORDS),
        .MEM_LATENCY (MEM_LATENCY),
        .MEM_WORDS   (MEM_WORDS)
    ) u_mem (
        .Clk       (Clk),
        .rst_n     (rst_n),
        .bus       (mem_bus.mem),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data)
    );

endmodule

`default_nettype wire
